/* Makefile */
.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_mem_system -f mem_system.f
	./obj_dir/Vtb_mem_system > sim.log 2>&1; cat sim.log
	grep -qxF '** PASS **' sim.log

lint:
	verilator --lint-only --timing -Wall --top-module tb_mem_system -f mem_system.f

clean:
	rm -rf obj_dir sim.log

/* mem_system.f */
verilog/mem_pkg.sv
verilog/bus_decoder.sv
verilog/scratch_ram.sv
verilog/sram_ctrl.sv
verilog/mem_system.sv
sim/sram_chip.sv
sim/mem_checker.sv
sim/mem_system_assertions.sv
sim/tb_mem_system.sv

/* sim/mem_checker.sv */
`timescale 1ns/1ps

module mem_checker (
    input logic                             clock,
    input logic                             reset,
    input logic                             mem_valid,
    input logic [mem_pkg::addr_width-1:0]   mem_addr,
    input logic [mem_pkg::data_width-1:0]   mem_wdata,
    input logic [mem_pkg::strb_width-1:0]   mem_wstrb,
    input logic                             mem_ready,
    input logic [mem_pkg::data_width-1:0]   mem_rdata,
    input logic                             mem_error
);
    import mem_pkg::*;

    localparam int sram_latency = 2 * (sram_wait_cycles + 1) + 1;

    int          error_count = 0;
    int          check_count = 0;
    logic [31:0] shadow [logic [29:0]];   // keyed by word address as the regions never overlap
    logic [3:0]  known  [logic [29:0]];   // lanes that were written
    logic        pending = 1'b0;
    int          latency;
    logic [31:0] req_addr;
    logic [31:0] req_wdata;
    logic [3:0]  req_wstrb;

    function automatic region_t expected_region(input logic [31:0] addr);
        if ((addr - scratch_base) < scratch_bytes) return region_scratch;
        if ((addr - sram_base) < sram_bytes) return region_sram;
        return region_none;
    endfunction

    task automatic report_value(input string name, input logic [31:0] expected, actual);
        $display("[ERROR] %0t %s: expected %h, got %h", $time, name, expected, actual);
        error_count++;
    endtask

    task automatic check_response();
        region_t     region;
        logic [29:0] key;
        logic [31:0] expected;
        logic [31:0] lane_mask;
        logic [3:0]  lanes;
        region   = expected_region(req_addr);
        key      = req_addr[31:2];
        lanes    = known.exists(key) ? known[key] : 4'b0000;
        expected = shadow.exists(key) ? shadow[key] : 32'h0;
        for (int lane = 0; lane < 4; lane++) begin
            lane_mask[lane*8 +: 8] = {8{lanes[lane]}};
        end
        check_count++;
        if (latency != ((region == region_sram) ? sram_latency : 1)) begin
            report_value("mem_ready latency", (region == region_sram) ? sram_latency : 1,
                         latency);
        end
        if (mem_error !== (region == region_none)) begin
            report_value("mem_error", region == region_none, mem_error);
        end
        if (region == region_none) begin
            if (mem_rdata !== 32'h0) report_value("mem_rdata", 32'h0, mem_rdata);
        end else begin
            // scratch returns the old word on a write while the SRAM returns nothing
            if ((region == region_scratch || req_wstrb == 4'b0000) &&
                (((mem_rdata ^ expected) & lane_mask) !== 32'h0)) begin
                report_value("mem_rdata", expected, mem_rdata);
            end
            for (int lane = 0; lane < 4; lane++) begin
                if (req_wstrb[lane]) begin
                    expected[lane*8 +: 8] = req_wdata[lane*8 +: 8];
                    lanes[lane] = 1'b1;
                end
            end
            shadow[key] = expected;
            known[key]  = lanes;
        end
    endtask

    always @(negedge clock) begin
        if (!reset) begin
            pending = 1'b0;
        end else begin
            if (pending) latency++;
            if (mem_ready) begin
                if (pending) begin
                    check_response();
                end else begin
                    $display("checker: mem_ready at %0t with no request outstanding", $time);
                    error_count++;
                end
                pending = 1'b0;
            end
            if (mem_valid) begin
                if (pending) begin
                    $display("checker: new request at %0t before the last one finished", $time);
                    error_count++;
                end
                pending   = 1'b1;
                latency   = 0;
                req_addr  = mem_addr;
                req_wdata = mem_wdata;
                req_wstrb = mem_wstrb;
            end
        end
    end

endmodule

/* sim/mem_system_assertions.sv */
`timescale 1ns/1ps

module mem_system_assertions (
    input logic                  clock,
    input logic                  reset,
    input mem_pkg::sram_state_t  state,
    input logic                  sram_valid,
    input logic                  sram_ready,
    input logic                  sram_ce_n,
    input logic                  sram_we_n,
    input logic                  sram_oe_n,
    input logic                  sram_ub_n,
    input logic                  sram_lb_n
);
    import mem_pkg::*;

    int failure_count = 0;

    idle_pins: assert property (@(posedge clock) disable iff (!reset)
        state == sram_idle |-> sram_ce_n && sram_we_n && sram_oe_n && sram_ub_n && sram_lb_n)
        else begin
            $error("SRAM strobes active while the controller is idle");
            failure_count++;
        end

    no_drive_fight: assert property (@(posedge clock) disable iff (!reset)
        !(!sram_we_n && !sram_oe_n))
        else begin
            $error("we_n and oe_n low together");
            failure_count++;
        end

    one_request: assert property (@(posedge clock) disable iff (!reset)
        state != sram_idle |-> !sram_valid)
        else begin
            $error("request arrived while an SRAM access is outstanding");
            failure_count++;
        end

    ready_pulse: assert property (@(posedge clock) disable iff (!reset)
        sram_ready |=> !sram_ready)
        else begin
            $error("ready held longer than one cycle");
            failure_count++;
        end

endmodule

bind sram_ctrl mem_system_assertions i_assertions (.*);

/* sim/sram_chip.sv */
`timescale 1ns/1ps

module sram_chip (
    input  logic                                  sram_ce_n,
    input  logic                                  sram_we_n,
    input  logic                                  sram_oe_n,
    input  logic                                  sram_ub_n,
    input  logic                                  sram_lb_n,
    input  logic [mem_pkg::sram_addr_width-1:0]   sram_addr,
    inout  wire  [mem_pkg::sram_data_width-1:0]   sram_dq
);
    import mem_pkg::*;

    logic [sram_data_width-1:0] cells [0:(1 << sram_addr_width)-1];
    logic                       read_en;

    assign read_en = !sram_ce_n && !sram_oe_n && sram_we_n;

    // each byte lane answers only when its enable is low
    assign sram_dq[15:8] = (read_en && !sram_ub_n) ? cells[sram_addr][15:8] : 8'bz;
    assign sram_dq[7:0]  = (read_en && !sram_lb_n) ? cells[sram_addr][7:0]  : 8'bz;

    // write once the pins have settled after any change
    always @(sram_ce_n or sram_we_n or sram_ub_n or sram_lb_n or sram_addr or sram_dq) begin
        #1;
        if (!sram_ce_n && !sram_we_n) begin
            if (!sram_ub_n) begin
                cells[sram_addr][15:8] = sram_dq[15:8];
            end
            if (!sram_lb_n) begin
                cells[sram_addr][7:0] = sram_dq[7:0];
            end
        end
    end

endmodule

/* sim/tb_mem_system.sv */
`timescale 1ns/1ps

module tb_mem_system;
    import mem_pkg::*;

    localparam int sram_latency   = 2 * (sram_wait_cycles + 1) + 1;
    localparam int scratch_pairs  = 32;
    localparam int sram_pairs     = 32;
    localparam int latency_probes = 8;
    localparam int unmapped_count = 16;
    localparam int mix_count      = 300;
    localparam int request_total  = 2 * scratch_pairs + 2 * sram_pairs + latency_probes
                                    + 2 * unmapped_count + mix_count;
    localparam int cycle_limit    = request_total * (sram_latency + 1) + 200;

    logic                        clock;
    logic                        reset;
    logic                        mem_valid;
    logic [addr_width-1:0]       mem_addr;
    logic [data_width-1:0]       mem_wdata;
    logic [strb_width-1:0]       mem_wstrb;
    logic                        mem_ready;
    logic [data_width-1:0]       mem_rdata;
    logic                        mem_error;
    logic                        sram_ce_n;
    logic                        sram_we_n;
    logic                        sram_oe_n;
    logic                        sram_ub_n;
    logic                        sram_lb_n;
    logic [sram_addr_width-1:0]  sram_addr;
    wire  [sram_data_width-1:0]  sram_dq;

    logic [31:0] rng_state;
    logic [31:0] scratch_addrs [scratch_pairs];
    logic [31:0] sram_addrs [sram_pairs];
    int          cycle_count;
    int          errors_before = 0;

    mem_system  i_dut (.*);
    sram_chip   i_sram_chip (.*);
    mem_checker i_checker (.*);

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic logic [3:0] random_strobe();
        logic [31:0] r;
        r = next_random();
        return (r[3:0] == 4'b0000) ? 4'b1111 : r[3:0];
    endfunction

    // starts on a rising edge and returns on the edge after mem_ready
    task automatic issue_request(input logic [31:0] addr, wdata, input logic [3:0] wstrb);
        mem_valid <= 1'b1;
        mem_addr  <= addr;
        mem_wdata <= wdata;
        mem_wstrb <= wstrb;
        @(posedge clock);
        mem_valid <= 1'b0;
        while (!mem_ready) @(posedge clock);
    endtask

    task automatic finish_test(input string name);
        int errors;
        errors = i_checker.error_count - errors_before;
        $display("test %-28s %0d errors", name, errors);
        errors_before = i_checker.error_count;
    endtask

    initial begin : stimulus
        logic [31:0] addr;
        logic [31:0] r;
        int          assertion_failures;
        reset = 1'b0;
        mem_valid = 1'b0;
        mem_addr = '0;
        mem_wdata = '0;
        mem_wstrb = '0;
        rng_state = 32'h6ae6;
        repeat (3) @(posedge clock);
        reset <= 1'b1;
        @(posedge clock);

        for (int i = 0; i < scratch_pairs; i++) begin
            scratch_addrs[i] = scratch_base + (next_random() & (scratch_bytes - 4));
            issue_request(scratch_addrs[i], next_random(), random_strobe());
        end
        for (int i = 0; i < scratch_pairs; i++) issue_request(scratch_addrs[i], 32'h0, 4'h0);
        finish_test("scratch write and read");

        // second half rewrites lanes of the first half's words
        for (int i = 0; i < sram_pairs; i++) begin
            if (i < sram_pairs / 2) begin
                sram_addrs[i] = sram_base + (next_random() & (sram_bytes - 4));
                issue_request(sram_addrs[i], next_random(), 4'b1111);
            end else begin
                sram_addrs[i] = sram_addrs[i - sram_pairs / 2];
                issue_request(sram_addrs[i], next_random(), random_strobe());
            end
        end
        for (int i = 0; i < sram_pairs; i++) issue_request(sram_addrs[i], 32'h0, 4'h0);
        finish_test("sram write and read");

        for (int i = 0; i < latency_probes; i++) begin
            issue_request(sram_addrs[i], next_random(), (i % 2 == 1) ? 4'b1111 : 4'b0000);
        end
        finish_test("sram latency");

        for (int i = 0; i < unmapped_count; i++) begin
            case (i % 4)
                0:       addr = 32'h0000_1000 | scratch_addrs[i];   // just past scratch
                1:       addr = sram_addrs[i] + sram_bytes;
                2:       addr = 32'h8000_0000 | scratch_addrs[i];
                default: addr = 32'hffff_fffc;
            endcase
            issue_request(addr, next_random(), 4'b1111);
        end
        for (int i = 0; i < unmapped_count; i++) begin
            issue_request((i % 2 == 0) ? scratch_addrs[i] : sram_addrs[i], 32'h0, 4'h0);
        end
        finish_test("unmapped addresses");

        for (int i = 0; i < mix_count; i++) begin
            r = next_random();
            case (r[1:0])
                2'd0, 2'd1: addr = scratch_base + ((r >> 8) & 32'h7c);  // small windows
                2'd2:       addr = sram_base + ((r >> 8) & 32'h7c);
                default:    addr = 32'h4000_0000 | ((r >> 8) & 32'h0fff_fffc);
            endcase
            issue_request(addr, next_random(), r[4] ? random_strobe() : 4'b0000);
        end
        finish_test("random mix");

        @(posedge clock);
        assertion_failures = i_dut.i_sram_ctrl.i_assertions.failure_count;
        $display("requests %0d, responses checked %0d, errors %0d, assertion failures %0d",
                 request_total, i_checker.check_count, i_checker.error_count,
                 assertion_failures);
        if (i_checker.check_count != request_total) begin
            $display("checker saw fewer or more responses than requests issued");
        end
        if (i_checker.error_count == 0 && assertion_failures == 0 &&
            i_checker.check_count == request_total) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin : watchdog
        cycle_count = 0;
        while (cycle_count < cycle_limit) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("timeout: run did not finish within %0d cycles", cycle_limit);
        $display("** FAIL **");
        $finish;
    end

endmodule

/* verilog/bus_decoder.sv */
`timescale 1ns/1ps

module bus_decoder (
    input  logic                             clock,
    input  logic                             reset,
    input  logic                             mem_valid,
    input  logic [mem_pkg::addr_width-1:0]   mem_addr,
    input  logic [mem_pkg::data_width-1:0]   mem_wdata,
    input  logic [mem_pkg::strb_width-1:0]   mem_wstrb,
    output logic                             mem_ready,
    output logic [mem_pkg::data_width-1:0]   mem_rdata,
    output logic                             mem_error,
    output logic                             scratch_valid,
    input  logic                             scratch_ready,
    input  logic [mem_pkg::data_width-1:0]   scratch_rdata,
    output logic                             sram_valid,
    input  logic                             sram_ready,
    input  logic [mem_pkg::data_width-1:0]   sram_rdata,
    output logic [mem_pkg::addr_width-1:0]   req_addr,
    output logic [mem_pkg::data_width-1:0]   req_wdata,
    output logic [mem_pkg::strb_width-1:0]   req_wstrb
);
    import mem_pkg::*;

    region_t region;
    region_t pending_region;
    logic    pending;
    logic    none_ready;

    // both regions are power-of-two sized and aligned
    always_comb begin
        if ((mem_addr & ~(scratch_bytes - 1)) == scratch_base) begin
            region = region_scratch;
        end else if ((mem_addr & ~(sram_bytes - 1)) == sram_base) begin
            region = region_sram;
        end else begin
            region = region_none;
        end
    end

    assign scratch_valid = mem_valid && (region == region_scratch);
    assign sram_valid    = mem_valid && (region == region_sram);

    // one request at a time, so the slaves share the request lines
    assign req_addr  = mem_addr;
    assign req_wdata = mem_wdata;
    assign req_wstrb = mem_wstrb;

    always_ff @(posedge clock) begin
        if (!reset) begin
            pending        <= 1'b0;
            pending_region <= region_none;
        end else if (mem_valid) begin
            pending        <= 1'b1;
            pending_region <= region;
        end else if (mem_ready) begin
            pending        <= 1'b0;
        end
    end

    // unmapped requests are answered here, one cycle after the strobe
    assign none_ready = pending && (pending_region == region_none);

    assign mem_ready = scratch_ready | sram_ready | none_ready;
    assign mem_error = none_ready;
    assign mem_rdata = scratch_ready ? scratch_rdata :
                       sram_ready    ? sram_rdata    : '0;

endmodule

/* verilog/mem_pkg.sv */
package mem_pkg;

    // CPU-side bus
    localparam int addr_width = 32;
    localparam int data_width = 32;
    localparam int strb_width = 4;

    // on-chip scratch RAM
    localparam int scratch_words = 1024;
    localparam int scratch_index_width = $clog2(scratch_words);
    localparam logic [addr_width-1:0] scratch_base = 32'h0000_0000;
    localparam logic [addr_width-1:0] scratch_bytes = scratch_words * 4;

    // external asynchronous SRAM, 256K x 16
    localparam logic [addr_width-1:0] sram_base = 32'h2000_0000;
    localparam logic [addr_width-1:0] sram_bytes = 32'h0008_0000;  // 512 KiB
    localparam int sram_addr_width = 18;       // halfword address
    localparam int sram_data_width = 16;

    // extra cycles each halfword phase holds the pins
    localparam int sram_wait_cycles = 3;
    localparam int sram_count_width =
        (sram_wait_cycles > 0) ? $clog2(sram_wait_cycles + 1) : 1;
    localparam logic [sram_count_width-1:0] sram_wait_last =
        sram_count_width'(sram_wait_cycles);

    typedef enum logic [1:0] {
        region_scratch,
        region_sram,
        region_none
    } region_t;

    // any strobe set makes it a write
    typedef enum logic {
        op_read,
        op_write
    } mem_op_t;

    typedef enum logic [1:0] {
        sram_idle,
        sram_low,      // halfword at bits 15:0
        sram_high      // halfword at bits 31:16
    } sram_state_t;

endpackage

/* verilog/mem_system.sv */
`timescale 1ns/1ps

module mem_system (
    input  logic                                  clock,
    input  logic                                  reset,
    input  logic                                  mem_valid,
    input  logic [mem_pkg::addr_width-1:0]        mem_addr,
    input  logic [mem_pkg::data_width-1:0]        mem_wdata,
    input  logic [mem_pkg::strb_width-1:0]        mem_wstrb,
    output logic                                  mem_ready,
    output logic [mem_pkg::data_width-1:0]        mem_rdata,
    output logic                                  mem_error,
    output logic                                  sram_ce_n,
    output logic                                  sram_we_n,
    output logic                                  sram_oe_n,
    output logic                                  sram_ub_n,
    output logic                                  sram_lb_n,
    output logic [mem_pkg::sram_addr_width-1:0]   sram_addr,
    inout  wire  [mem_pkg::sram_data_width-1:0]   sram_dq
);
    import mem_pkg::*;

    logic                  scratch_valid;
    logic                  scratch_ready;
    logic [data_width-1:0] scratch_rdata;
    logic                  sram_valid;
    logic                  sram_ready;
    logic [data_width-1:0] sram_rdata;
    logic [addr_width-1:0] req_addr;
    logic [data_width-1:0] req_wdata;
    logic [strb_width-1:0] req_wstrb;

    bus_decoder i_bus_decoder (
        .clock         (clock),
        .reset         (reset),
        .mem_valid     (mem_valid),
        .mem_addr      (mem_addr),
        .mem_wdata     (mem_wdata),
        .mem_wstrb     (mem_wstrb),
        .mem_ready     (mem_ready),
        .mem_rdata     (mem_rdata),
        .mem_error     (mem_error),
        .scratch_valid (scratch_valid),
        .scratch_ready (scratch_ready),
        .scratch_rdata (scratch_rdata),
        .sram_valid    (sram_valid),
        .sram_ready    (sram_ready),
        .sram_rdata    (sram_rdata),
        .req_addr      (req_addr),
        .req_wdata     (req_wdata),
        .req_wstrb     (req_wstrb)
    );

    scratch_ram i_scratch_ram (
        .clock         (clock),
        .reset         (reset),
        .scratch_valid (scratch_valid),
        .req_addr      (req_addr),
        .req_wdata     (req_wdata),
        .req_wstrb     (req_wstrb),
        .scratch_ready (scratch_ready),
        .scratch_rdata (scratch_rdata)
    );

    sram_ctrl i_sram_ctrl (
        .clock      (clock),
        .reset      (reset),
        .sram_valid (sram_valid),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .req_wstrb  (req_wstrb),
        .sram_ready (sram_ready),
        .sram_rdata (sram_rdata),
        .sram_ce_n  (sram_ce_n),
        .sram_we_n  (sram_we_n),
        .sram_oe_n  (sram_oe_n),
        .sram_ub_n  (sram_ub_n),
        .sram_lb_n  (sram_lb_n),
        .sram_addr  (sram_addr),
        .sram_dq    (sram_dq)
    );

endmodule

/* verilog/scratch_ram.sv */
`timescale 1ns/1ps

module scratch_ram (
    input  logic                             clock,
    input  logic                             reset,
    input  logic                             scratch_valid,
    input  logic [mem_pkg::addr_width-1:0]   req_addr,
    input  logic [mem_pkg::data_width-1:0]   req_wdata,
    input  logic [mem_pkg::strb_width-1:0]   req_wstrb,
    output logic                             scratch_ready,
    output logic [mem_pkg::data_width-1:0]   scratch_rdata
);
    import mem_pkg::*;

    logic [data_width-1:0]          ram [0:scratch_words-1];
    logic [scratch_index_width-1:0] index;

    assign index = req_addr[scratch_index_width+1:2];  // word index

    always_ff @(posedge clock) begin
        if (scratch_valid) begin
            for (int lane = 0; lane < strb_width; lane++) begin
                if (req_wstrb[lane]) begin
                    ram[index][lane*8 +: 8] <= req_wdata[lane*8 +: 8];
                end
            end
            scratch_rdata <= ram[index];   // old word, before this write
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            scratch_ready <= 1'b0;
        end else begin
            scratch_ready <= scratch_valid;
        end
    end

endmodule

/* verilog/sram_ctrl.sv */
`timescale 1ns/1ps

module sram_ctrl (
    input  logic                                  clock,
    input  logic                                  reset,
    input  logic                                  sram_valid,
    input  logic [mem_pkg::addr_width-1:0]        req_addr,
    input  logic [mem_pkg::data_width-1:0]        req_wdata,
    input  logic [mem_pkg::strb_width-1:0]        req_wstrb,
    output logic                                  sram_ready,
    output logic [mem_pkg::data_width-1:0]        sram_rdata,
    output logic                                  sram_ce_n,
    output logic                                  sram_we_n,
    output logic                                  sram_oe_n,
    output logic                                  sram_ub_n,
    output logic                                  sram_lb_n,
    output logic [mem_pkg::sram_addr_width-1:0]   sram_addr,
    inout  wire  [mem_pkg::sram_data_width-1:0]   sram_dq
);
    import mem_pkg::*;

    sram_state_t                 state;
    mem_op_t                     op;
    logic [sram_count_width-1:0] wait_count;
    logic [data_width-1:0]       wdata;
    logic [strb_width-1:0]       strb;
    logic [sram_data_width-1:0]  dq_out;

    // pin values for the phase that starts on this edge
    logic                        phase_write;
    logic [sram_data_width-1:0]  phase_dq;
    logic [1:0]                  phase_strb;

    always_comb begin
        if (state == sram_idle) begin
            // low phase, taken straight from the request
            phase_write = |req_wstrb;
            phase_dq    = req_wdata[15:0];
            phase_strb  = req_wstrb[1:0];
        end else begin
            phase_write = (op == op_write);
            phase_dq    = wdata[31:16];
            phase_strb  = strb[3:2];
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            state      <= sram_idle;
            wait_count <= '0;
            sram_ready <= 1'b0;
            sram_ce_n  <= 1'b1;
            sram_we_n  <= 1'b1;
            sram_oe_n  <= 1'b1;
            sram_ub_n  <= 1'b1;
            sram_lb_n  <= 1'b1;
        end else begin
            sram_ready <= 1'b0;
            case (state)
                sram_idle: begin
                    if (sram_valid) begin
                        op         <= phase_write ? op_write : op_read;
                        wdata      <= req_wdata;
                        strb       <= req_wstrb;
                        sram_addr  <= {req_addr[sram_addr_width:2], 1'b0};
                        wait_count <= '0;
                        state      <= sram_low;
                    end
                end
                sram_low: begin
                    if (wait_count == sram_wait_last) begin
                        if (op == op_read) begin
                            sram_rdata[15:0] <= sram_dq;
                        end
                        sram_addr[0] <= 1'b1;   // upper halfword
                        wait_count   <= '0;
                        state        <= sram_high;
                    end else begin
                        wait_count <= wait_count + 1'b1;
                    end
                end
                sram_high: begin
                    if (wait_count == sram_wait_last) begin
                        if (op == op_read) begin
                            sram_rdata[31:16] <= sram_dq;
                        end
                        sram_ready <= 1'b1;
                        state      <= sram_idle;
                    end else begin
                        wait_count <= wait_count + 1'b1;
                    end
                end
                default: state <= sram_idle;
            endcase

            // pins switch together with the state
            if ((state == sram_idle && sram_valid) ||
                (state == sram_low && wait_count == sram_wait_last)) begin
                sram_ce_n <= 1'b0;
                sram_we_n <= ~phase_write;
                sram_oe_n <= phase_write;
                sram_ub_n <= phase_write ? ~phase_strb[1] : 1'b0;
                sram_lb_n <= phase_write ? ~phase_strb[0] : 1'b0;
                dq_out    <= phase_dq;
            end else if (state == sram_high && wait_count == sram_wait_last) begin
                sram_ce_n <= 1'b1;
                sram_we_n <= 1'b1;
                sram_oe_n <= 1'b1;
                sram_ub_n <= 1'b1;
                sram_lb_n <= 1'b1;
            end
        end
    end

    assign sram_dq = sram_we_n ? 'z : dq_out;   // drive only while writing

endmodule
